// ==== Makefile ====
TOP = opl3_host_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f sources.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "TESTBENCH FAILED" $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/opl3_host_properties.sv ====
// concurrent checks on register-write pulses, reset state of o_reg_wr and the irq pin
module opl3_host_properties (
    input logic clk_opl3,
    input logic i_reset_opl3,
    input logic i_fifo_empty, // read side of the crossing fifo
    input opl3_pkg::opl3_reg_wr_t i_reg_wr,
    input opl3_pkg::status_t i_status,
    input logic i_irq_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // a pulse needs an entry popped one cycle earlier, so no repeats per entry
    assert property (@(posedge clk_opl3) disable iff (i_reset_opl3)
        i_reg_wr.valid |-> !$past(i_fifo_empty))
        else $error("o_reg_wr.valid seen without a fifo entry in the previous cycle");

    // decode output fully cleared by reset
    assert property (@(posedge clk_opl3) $past(i_reset_opl3) |-> i_reg_wr == '0)
        else $error("o_reg_wr not zero in the cycle after reset");

    assert property (@(posedge clk_opl3) i_irq_n == !i_status.irq)
        else $error("o_irq_n does not follow the irq status bit");
endmodule

// attached at the top, where decode, status and the irq pin all meet
bind opl3_host_top opl3_host_properties u_properties (
    .clk_opl3(clk_opl3),
    .i_reset_opl3(reset_opl3),
    .i_fifo_empty(u_host_if.fifo_empty),
    .i_reg_wr(o_reg_wr),
    .i_status(status),
    .i_irq_n(o_irq_n)
);

// ==== bench/opl3_host_tb.sv ====
// testbench top: xorshift bus stimulus, register write model and monitor, status reads, watchdog
module opl3_host_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import opl3_pkg::*;

    localparam int NUM_OPS = 32; // random address/data port operations
    localparam int NUM_WRITES = 2 * NUM_OPS + 16;
    localparam int TIMER_WAIT_CYCLES = 20 * TIMER1_TICK_CYCLES + 32 * TIMER2_TICK_CYCLES + 300;
    localparam int WATCHDOG_NS = NUM_WRITES * 200 + TIMER_WAIT_CYCLES * 20 + 3000;

    logic clk_host;
    logic clk_opl3;
    logic por_reset;
    logic mid_reset; // reset pulse in the middle of traffic
    logic reset;
    logic cs_n;
    logic rd_n;
    logic wr_n;
    logic [HOST_ADDR_WIDTH-1:0] address;
    logic [REG_FILE_DATA_WIDTH-1:0] din;
    logic [REG_FILE_DATA_WIDTH-1:0] dout;
    opl3_reg_wr_t reg_wr;
    logic irq_n;

    opl3_reg_wr_t expected_q [$]; // data port writes not yet seen on o_reg_wr
    logic model_bank; // address port state of the model
    logic [REG_FILE_DATA_WIDTH-1:0] model_index;
    logic flushing; // writes lost to reset go unchecked
    logic [31:0] rng_state;

    tb_clocks u_clocks (
        .clk_host(clk_host),
        .clk_opl3(clk_opl3),
        .o_reset(por_reset)
    );

    assign reset = por_reset || mid_reset;

    opl3_host_top u_dut (
        .clk_host(clk_host),
        .clk_opl3(clk_opl3),
        .reset(reset),
        .i_cs_n(cs_n),
        .i_rd_n(rd_n),
        .i_wr_n(wr_n),
        .i_address(address),
        .i_din(din),
        .o_dout(dout),
        .o_reg_wr(reg_wr),
        .o_irq_n(irq_n)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // status byte as the host should read it, irq in bit 7
    function automatic logic [7:0] status_byte(input logic irq, input logic t1, input logic t2);
        return {irq, t1, t2, 5'b00000};
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic irq_rst, input logic mask_t1,
            input logic mask_t2, input logic start_t2, input logic start_t1);
        return {irq_rst, mask_t1, mask_t2, 3'b000, start_t2, start_t1};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h",
                $time, name, got, exp));
    endtask

    // strobe low for one clk_host cycle, then idle so the fifo keeps up
    task automatic bus_write(input logic [1:0] port, input logic [7:0] value);
        @(negedge clk_host);
        cs_n = 1'b0;
        wr_n = 1'b0;
        address = port;
        din = value;
        @(negedge clk_host);
        cs_n = 1'b1;
        wr_n = 1'b1;
        address = '0; // idle on the status port
        repeat (2) @(negedge clk_host);
    endtask

    task automatic bus_read(input logic [1:0] port, output logic [7:0] value);
        @(negedge clk_host);
        cs_n = 1'b0;
        rd_n = 1'b0;
        address = port;
        repeat (2) @(negedge clk_host); // address register, then read mux register
        value = dout;
        cs_n = 1'b1;
        rd_n = 1'b1;
        address = '0;
    endtask

    task automatic address_write(input logic bank, input logic [7:0] index);
        model_bank = bank;
        model_index = index;
        bus_write({bank, 1'b0}, index); // no pulse expected
    endtask

    task automatic data_write(input logic [7:0] value);
        expected_q.push_back({1'b1, model_bank, model_index, value});
        bus_write({model_bank, 1'b1}, value);
    endtask

    task automatic reg_write(input logic bank, input logic [7:0] index, input logic [7:0] value);
        address_write(bank, index);
        data_write(value);
    endtask

    // 0 address only, 1 data only to the last address, else a full pair
    task automatic random_op();
        logic bank;
        logic [7:0] index;
        rng_state = xorshift32(rng_state);
        bank = rng_state[8];
        index = rng_state[7:0];
        if (!bank && index >= REG_TIMER1 && index <= REG_TIMER_CTRL)
            index = index | 8'h40; // keeps the timers idle
        if (rng_state[31:30] != 2'd1)
            address_write(bank, index);
        if (rng_state[31:30] != 2'd0)
            data_write(rng_state[23:16]);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(negedge clk_opl3);
            cycles++;
            if (cycles > 100)
                stop_on_error("a register write did not reach o_reg_wr within 100 clk_opl3 cycles");
        end
    endtask

    // each pulse takes the oldest expected write
    always @(negedge clk_opl3) begin : reg_wr_monitor
        opl3_reg_wr_t exp;
        if (reg_wr.valid === 1'b1 && !flushing) begin
            if (expected_q.size() == 0) begin
                stop_on_error("o_reg_wr.valid pulsed with no data port write pending");
            end else begin
                exp = expected_q.pop_front();
                check_value("o_reg_wr", 32'(reg_wr), 32'(exp));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before all tests finished");
    end

    initial begin
        logic [REG_FILE_DATA_WIDTH-1:0] value;
        cs_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        address = '0;
        din = '0;
        mid_reset = 1'b0;
        flushing = 1'b0;
        model_bank = 1'b0;
        model_index = '0;
        rng_state = 32'h14cf_40d4;
        repeat (10) @(negedge clk_opl3); // opl3 side reset trails the host reset

        // status clear after reset, other ports all ones
        bus_read(2'd0, value);
        check_value("o_dout addr 0", 32'(value), 32'(status_byte(1'b0, 1'b0, 1'b0)));
        for (int port = 1; port < 4; port++) begin
            bus_read(2'(port), value);
            check_value("o_dout addr 1-3", 32'(value), 32'hff);
        end
        check_value("o_irq_n", 32'(irq_n), 32'd1);

        for (int i = 0; i < NUM_OPS; i++)
            random_op();
        wait_drain();
        repeat (10) @(negedge clk_opl3); // a stray pulse would hit the monitor here

        // timer 1 from 0xf0, 16 ticks to overflow
        reg_write(1'b0, REG_TIMER1, 8'hf0);
        reg_write(1'b0, REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
        wait_drain();
        repeat (20 * TIMER1_TICK_CYCLES + 10) @(negedge clk_opl3);
        bus_read(2'd0, value);
        check_value("status after t1 overflow", 32'(value), 32'(status_byte(1'b1, 1'b1, 1'b0)));
        check_value("o_irq_n after t1 overflow", 32'(irq_n), 32'd0);

        // timer 1 stopped, timer 2 masked and running for two periods
        reg_write(1'b0, REG_TIMER2, 8'hf0);
        reg_write(1'b0, REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b1, 1'b1, 1'b0));
        wait_drain();
        repeat (32 * TIMER2_TICK_CYCLES) @(negedge clk_opl3);
        bus_read(2'd0, value);
        check_value("status with t2 masked", 32'(value), 32'(status_byte(1'b1, 1'b1, 1'b0)));
        reg_write(1'b0, REG_TIMER_CTRL, ctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        wait_drain();
        repeat (10) @(negedge clk_opl3);
        bus_read(2'd0, value);
        check_value("status after irq reset", 32'(value), 32'(status_byte(1'b0, 1'b0, 1'b0)));
        check_value("o_irq_n after irq reset", 32'(irq_n), 32'd1);

        // timer 1 running and writes in flight when reset hits
        reg_write(1'b0, REG_TIMER1, 8'hf0);
        reg_write(1'b0, REG_TIMER_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
        wait_drain();
        flushing = 1'b1;
        address_write(1'b0, 8'h40); // keeps data-only ops off the timer control register
        for (int i = 0; i < 3; i++)
            random_op();
        @(negedge clk_host);
        address = 2'd3; // would read 0xff here unless reset clears o_dout
        mid_reset = 1'b1;
        repeat (8) @(negedge clk_host); // longer than one clk_opl3 period
        check_value("o_dout during reset", 32'(dout), 32'd0);
        mid_reset = 1'b0;
        address = '0;
        repeat (4) @(negedge clk_opl3);
        check_value("o_reg_wr after reset", 32'(reg_wr), 32'd0);
        expected_q.delete();
        model_bank = 1'b0;
        model_index = '0;
        flushing = 1'b0;
        repeat (100) @(negedge clk_opl3); // a live timer 1 would overflow in here
        bus_read(2'd0, value);
        check_value("status after reset", 32'(value), 32'(status_byte(1'b0, 1'b0, 1'b0)));
        check_value("o_irq_n after reset", 32'(irq_n), 32'd1);

        $display("TESTBENCH PASSED");
        $finish;
    end
endmodule

// ==== bench/tb_clocks.sv ====
// testbench clocks for clk_host and clk_opl3, power-on reset pulse
module tb_clocks (
    output logic clk_host,
    output logic clk_opl3,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_host = 1'b0;
        forever #4 clk_host = ~clk_host; // 8 ns period
    end

    initial begin
        clk_opl3 = 1'b0;
        forever #10 clk_opl3 = ~clk_opl3; // 20 ns, unrelated to the host clock
    end

    // two rising clk_host edges, also spans one clk_opl3 edge for the synchronizer
    initial begin
        o_reset = 1'b1;
        repeat (2) @(negedge clk_host);
        o_reset = 1'b0;
    end
endmodule

// ==== common/opl3_pkg.sv ====
// opl3 host path package: bus widths, register indices, timer ticks, register-write and status types
package opl3_pkg;
    localparam int REG_FILE_DATA_WIDTH = 8; // one register byte
    localparam int HOST_ADDR_WIDTH = 2; // A1:A0 of the isa-style port
    localparam int AFIFO_LG_DEPTH = 4; // 16 entries, host to opl3 crossing

    // bank 0 timer registers
    localparam logic [REG_FILE_DATA_WIDTH-1:0] REG_TIMER1 = 8'h02;
    localparam logic [REG_FILE_DATA_WIDTH-1:0] REG_TIMER2 = 8'h03;
    localparam logic [REG_FILE_DATA_WIDTH-1:0] REG_TIMER_CTRL = 8'h04;

    // clk_opl3 cycles per count, scaled down from 80 us and 320 us
    // both must be powers of two, timer 2 the longer one
    localparam int TIMER1_TICK_CYCLES = 4;
    localparam int TIMER2_TICK_CYCLES = 16;

    typedef struct packed {
        logic valid; // one cycle per data port write
        logic bank_num; // from address port A1
        logic [REG_FILE_DATA_WIDTH-1:0] address;
        logic [REG_FILE_DATA_WIDTH-1:0] data;
    } opl3_reg_wr_t;

    // control byte when irq reset is requested, other bits don't care
    typedef struct packed {
        logic irq_rst;
        logic [6:0] ignored;
    } timer_ctrl_irq_t;

    // control byte when irq reset is clear
    typedef struct packed {
        logic irq_rst;
        logic mask_t1;
        logic mask_t2;
        logic [2:0] unused;
        logic start_t2;
        logic start_t1;
    } timer_ctrl_bits_t;

    typedef union packed {
        timer_ctrl_irq_t irq;
        timer_ctrl_bits_t ctrl;
    } timer_ctrl_u;

    typedef struct packed {
        logic irq; // either flag set
        logic flag_t1;
        logic flag_t2;
        logic [4:0] zero;
    } status_t;
endpackage

// ==== hw/host_if/afifo.sv ====
// asynchronous fifo with gray-coded pointers and separate write and read side resets
module afifo #(
    parameter int LGFIFO = 4, // log2 depth, at least 2
    parameter int WIDTH = 10
) (
    input logic i_wclk,
    input logic i_wr_reset, // synchronous to i_wclk
    input logic i_wr,
    input logic [WIDTH-1:0] i_wr_data,
    output logic o_wr_full,
    input logic i_rclk,
    input logic i_rd_reset, // synchronous to i_rclk
    input logic i_rd,
    output logic [WIDTH-1:0] o_rd_data,
    output logic o_rd_empty
);
    logic [WIDTH-1:0] mem [0:(1<<LGFIFO)-1];

    // pointers carry one extra bit to tell full from empty
    logic [LGFIFO:0] wbin, wbin_next;
    logic [LGFIFO:0] wgray, wgray_next;
    logic [LGFIFO:0] rbin, rbin_next;
    logic [LGFIFO:0] rgray, rgray_next;

    logic [LGFIFO:0] rgray_meta, rgray_sync; // read pointer seen by write side
    logic [LGFIFO:0] wgray_meta, wgray_sync; // write pointer seen by read side

    logic do_write;
    logic do_read;

    assign do_write = i_wr && !o_wr_full; // writes while full are lost
    assign do_read = i_rd && !o_rd_empty;

    // write side
    assign wbin_next = wbin + {{LGFIFO{1'b0}}, do_write};
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge i_wclk) begin
        if (i_wr_reset) begin
            wbin <= '0;
            wgray <= '0;
            o_wr_full <= 1'b0;
        end else begin
            wbin <= wbin_next;
            wgray <= wgray_next;
            // full when top two gray bits differ and the rest match
            o_wr_full <= wgray_next == {~rgray_sync[LGFIFO:LGFIFO-1], rgray_sync[LGFIFO-2:0]};
        end
    end

    always_ff @(posedge i_wclk) begin
        if (do_write)
            mem[wbin[LGFIFO-1:0]] <= i_wr_data;
    end

    always_ff @(posedge i_wclk) begin
        if (i_wr_reset) begin
            rgray_meta <= '0;
            rgray_sync <= '0;
        end else begin
            rgray_meta <= rgray;
            rgray_sync <= rgray_meta;
        end
    end

    // read side
    assign rbin_next = rbin + {{LGFIFO{1'b0}}, do_read};
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge i_rclk) begin
        if (i_rd_reset) begin
            rbin <= '0;
            rgray <= '0;
            o_rd_empty <= 1'b1;
        end else begin
            rbin <= rbin_next;
            rgray <= rgray_next;
            o_rd_empty <= rgray_next == wgray_sync; // caught up with writer
        end
    end

    always_ff @(posedge i_rclk) begin
        if (i_rd_reset) begin
            wgray_meta <= '0;
            wgray_sync <= '0;
        end else begin
            wgray_meta <= wgray;
            wgray_sync <= wgray_meta;
        end
    end

    assign o_rd_data = mem[rbin[LGFIFO-1:0]]; // first word fall through
endmodule

// ==== hw/host_if/host_if.sv ====
// host bus capture, clk_opl3 reset synchronizer, crossing fifo and address/data port decode
module host_if (
    input logic clk_host,
    input logic clk_opl3,
    input logic reset, // clk_host domain
    input logic i_cs_n,
    input logic i_wr_n,
    input logic [opl3_pkg::HOST_ADDR_WIDTH-1:0] i_address,
    input logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] i_din,
    output logic [opl3_pkg::HOST_ADDR_WIDTH-1:0] o_address_p1,
    output logic o_reset_opl3,
    output opl3_pkg::opl3_reg_wr_t o_reg_wr
);
    import opl3_pkg::*;

    logic cs_p1_n;
    logic wr_p1_n;
    logic [REG_FILE_DATA_WIDTH-1:0] din_p1;
    logic wr_p1;

    logic reset_meta_opl3;

    logic fifo_empty;
    logic [HOST_ADDR_WIDTH-1:0] fifo_address;
    logic [REG_FILE_DATA_WIDTH-1:0] fifo_data;

    // bus pins registered first, relaxes the pad timing
    always_ff @(posedge clk_host) begin
        if (reset) begin
            cs_p1_n <= 1'b1;
            wr_p1_n <= 1'b1;
        end else begin
            cs_p1_n <= i_cs_n;
            wr_p1_n <= i_wr_n;
        end
    end

    always_ff @(posedge clk_host) begin
        o_address_p1 <= i_address; // also selects the read data
        din_p1 <= i_din;
    end

    // one fifo entry per cycle the strobe is held low
    assign wr_p1 = !cs_p1_n && !wr_p1_n;

    // host reset must last longer than one clk_opl3 period to be seen here
    always_ff @(posedge clk_opl3) begin
        reset_meta_opl3 <= reset;
        o_reset_opl3 <= reset_meta_opl3;
    end

    afifo #(
        .LGFIFO(AFIFO_LG_DEPTH),
        .WIDTH(HOST_ADDR_WIDTH + REG_FILE_DATA_WIDTH) // port address + data byte
    ) u_afifo (
        .i_wclk(clk_host),
        .i_wr_reset(reset),
        .i_wr(wr_p1),
        .i_wr_data({o_address_p1, din_p1}),
        .o_wr_full(), // no back-pressure, host paces its writes
        .i_rclk(clk_opl3),
        .i_rd_reset(o_reset_opl3),
        .i_rd(!fifo_empty), // drain as fast as entries arrive
        .o_rd_data({fifo_address, fifo_data}),
        .o_rd_empty(fifo_empty)
    );

    // address port sets bank and index, data port fires the write
    always_ff @(posedge clk_opl3) begin
        if (o_reset_opl3) begin
            o_reg_wr <= '0;
        end else begin
            o_reg_wr.valid <= 1'b0; // pulse only
            if (!fifo_empty) begin
                if (!fifo_address[0]) begin // address port
                    o_reg_wr.bank_num <= fifo_address[1];
                    o_reg_wr.address <= fifo_data;
                end else begin // data port
                    o_reg_wr.data <= fifo_data;
                    o_reg_wr.valid <= 1'b1;
                end
            end
        end
    end
endmodule

// ==== hw/opl3_host_top.sv ====
// top level wiring of host decode, timer execute and status result blocks
module opl3_host_top (
    input logic clk_host,
    input logic clk_opl3,
    input logic reset, // synchronous to clk_host
    input logic i_cs_n,
    input logic i_rd_n, // reads have no side effects, o_dout is always valid
    input logic i_wr_n,
    input logic [opl3_pkg::HOST_ADDR_WIDTH-1:0] i_address,
    input logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] i_din,
    output logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] o_dout,
    output opl3_pkg::opl3_reg_wr_t o_reg_wr, // clk_opl3 domain
    output logic o_irq_n
);
    import opl3_pkg::*;

    logic [HOST_ADDR_WIDTH-1:0] address_p1;
    logic reset_opl3;
    status_t status;

    host_if u_host_if (
        .clk_host(clk_host),
        .clk_opl3(clk_opl3),
        .reset(reset),
        .i_cs_n(i_cs_n),
        .i_wr_n(i_wr_n),
        .i_address(i_address),
        .i_din(i_din),
        .o_address_p1(address_p1),
        .o_reset_opl3(reset_opl3),
        .o_reg_wr(o_reg_wr)
    );

    // timers see every register write that leaves the top
    opl3_timers u_opl3_timers (
        .clk_opl3(clk_opl3),
        .i_reset(reset_opl3),
        .i_reg_wr(o_reg_wr),
        .o_status(status),
        .o_irq_n(o_irq_n)
    );

    status_port u_status_port (
        .clk_host(clk_host),
        .i_reset(reset),
        .i_status(status),
        .i_address_p1(address_p1),
        .o_dout(o_dout)
    );
endmodule

// ==== hw/opl3_timers.sv ====
// timer preset and control registers, shared tick prescaler, two 8-bit timers, status byte
module opl3_timers (
    input logic clk_opl3,
    input logic i_reset,
    input opl3_pkg::opl3_reg_wr_t i_reg_wr,
    output opl3_pkg::status_t o_status,
    output logic o_irq_n
);
    import opl3_pkg::*;

    // index 0 is timer 1, index 1 is timer 2
    logic [REG_FILE_DATA_WIDTH-1:0] preset [2];
    logic [REG_FILE_DATA_WIDTH-1:0] count [2];
    logic [1:0] preset_wr;
    logic [1:0] start;
    logic [1:0] mask;
    logic [1:0] tick;
    logic [1:0] ovf;

    logic [$clog2(TIMER2_TICK_CYCLES)-1:0] prescale;

    logic bank0_wr;
    logic ctrl_wr;
    timer_ctrl_u ctrl;
    status_t status_next;

    assign bank0_wr = i_reg_wr.valid && !i_reg_wr.bank_num;
    assign preset_wr[0] = bank0_wr && i_reg_wr.address == REG_TIMER1;
    assign preset_wr[1] = bank0_wr && i_reg_wr.address == REG_TIMER2;
    assign ctrl_wr = bank0_wr && i_reg_wr.address == REG_TIMER_CTRL;
    assign ctrl = i_reg_wr.data; // same byte, two views

    // masks and starts only change when irq reset is clear
    always_ff @(posedge clk_opl3) begin
        if (i_reset) begin
            start <= 2'b00;
            mask <= 2'b00;
        end else if (ctrl_wr && !ctrl.irq.irq_rst) begin
            start[0] <= ctrl.ctrl.start_t1;
            start[1] <= ctrl.ctrl.start_t2;
            mask[0] <= ctrl.ctrl.mask_t1;
            mask[1] <= ctrl.ctrl.mask_t2;
        end
    end

    // free running, timer 2 wraps once per full prescaler turn
    always_ff @(posedge clk_opl3) begin
        if (i_reset)
            prescale <= '0;
        else
            prescale <= prescale + 1'b1;
    end

    // power-of-two tick periods, so all low bits set marks the tick
    assign tick[0] = prescale[$clog2(TIMER1_TICK_CYCLES)-1:0] == '1;
    assign tick[1] = prescale == '1;

    for (genvar i = 0; i < 2; i++) begin : g_timer
        always_ff @(posedge clk_opl3) begin
            if (i_reset)
                preset[i] <= '0;
            else if (preset_wr[i])
                preset[i] <= i_reg_wr.data;
        end

        assign ovf[i] = start[i] && tick[i] && count[i] == '1; // past 255

        always_ff @(posedge clk_opl3) begin
            if (i_reset)
                count[i] <= '0;
            else if (!start[i])
                count[i] <= preset[i]; // stopped timer sits at its preset
            else if (ovf[i])
                count[i] <= preset[i]; // reload
            else if (tick[i])
                count[i] <= count[i] + 1'b1;
        end
    end

    always_comb begin
        status_next = o_status;
        if (ovf[0] && !mask[0])
            status_next.flag_t1 = 1'b1;
        if (ovf[1] && !mask[1])
            status_next.flag_t2 = 1'b1;
        // irq reset wins over an overflow in the same cycle
        if (ctrl_wr && ctrl.irq.irq_rst) begin
            status_next.flag_t1 = 1'b0;
            status_next.flag_t2 = 1'b0;
        end
        status_next.irq = status_next.flag_t1 || status_next.flag_t2;
        status_next.zero = '0;
    end

    always_ff @(posedge clk_opl3) begin
        if (i_reset)
            o_status <= '0;
        else
            o_status <= status_next;
    end

    assign o_irq_n = !o_status.irq; // active low pin
endmodule

// ==== hw/status_port.sv ====
// status byte synchronizer into clk_host and registered host read data mux
module status_port (
    input logic clk_host,
    input logic i_reset,
    input opl3_pkg::status_t i_status, // clk_opl3 domain
    input logic [opl3_pkg::HOST_ADDR_WIDTH-1:0] i_address_p1,
    output logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0] o_dout
);
    import opl3_pkg::*;

    status_t status_meta;
    status_t status_sync;

    // bits are independent flags, no need for a coherent capture
    always_ff @(posedge clk_host) begin
        if (i_reset) begin
            status_meta <= '0;
            status_sync <= '0;
        end else begin
            status_meta <= i_status;
            status_sync <= status_meta;
        end
    end

    // only address 0 returns status
    // software probes other addresses expecting all ones
    always_ff @(posedge clk_host) begin
        if (i_reset)
            o_dout <= '0;
        else if (i_address_p1 == '0)
            o_dout <= status_sync;
        else
            o_dout <= '1;
    end
endmodule

// ==== sources.f ====
common/opl3_pkg.sv
hw/host_if/afifo.sv
hw/host_if/host_if.sv
hw/opl3_timers.sv
hw/status_port.sv
hw/opl3_host_top.sv
bench/tb_clocks.sv
bench/opl3_host_properties.sv
bench/opl3_host_tb.sv
